/* rtl/isa_pkg.sv */
package isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] operand;
  } insn_t;

  localparam logic [7:0] OP_PUSH  = 8'h01;
  localparam logic [7:0] OP_OUT   = 8'h02;
  localparam logic [7:0] OP_ADD   = 8'h03;
  localparam logic [7:0] OP_SUB   = 8'h04;
  localparam logic [7:0] OP_MUL   = 8'h05;
  localparam logic [7:0] OP_STORE = 8'h06;
  localparam logic [7:0] OP_LOAD  = 8'h07;

  // halt is the whole word, not just the opcode byte
  localparam insn_t INSN_HALT = '{opcode: 8'hff, operand: 8'hff};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand stack
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int STACK_DEPTH = 8;

  typedef enum logic [2:0] {
    STK_NONE,
    STK_PUSH,
    STK_ADD,
    STK_SUB,
    STK_MUL,
    STK_DROP2,
    STK_POP
  } stack_op_t;

  // every instruction walks through these four phases in order
  typedef enum logic [1:0] {
    PH_EXEC,
    PH_ADDR,
    PH_ACCESS,
    PH_ADVANCE
  } phase_t;

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int PC_W       = 10;
  localparam int DATA_W     = 8;
  localparam int IMEM_DEPTH = 1024;
  localparam int DMEM_DEPTH = 256;
  localparam int DADDR_W    = $clog2(DMEM_DEPTH);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // port bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one program word as written by the loader
  typedef struct packed {
    logic [PC_W-1:0] addr;
    isa_pkg::insn_t  word;
  } prog_load_t;

  // address is live, strobe and data are registered in the core
  typedef struct packed {
    logic [DADDR_W-1:0] addr;
    logic               we;
    logic [DATA_W-1:0]  wdata;
  } dmem_req_t;

endpackage

/* rtl/word_mem.sv */
module word_mem #(
  parameter type word_t = logic [7:0],
  parameter int  DEPTH  = 256
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  word_t                    wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output word_t                    rdata
);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read data shows up one cycle after the address
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* rtl/operand_stack.sv */
module operand_stack (
  input  logic               clk,
  input  logic               rst,
  input  isa_pkg::stack_op_t op,
  input  logic [7:0]         push_data,
  output logic [7:0]         top,
  output logic [7:0]         second
);

  logic [7:0] ent [isa_pkg::STACK_DEPTH];
  logic [7:0] new_top;

  assign top    = ent[0];
  assign second = ent[1];

  // value that lands in entry 0 for push and the binary actions
  always_comb begin
    case (op)
      isa_pkg::STK_ADD: new_top = ent[1] + ent[0];
      isa_pkg::STK_SUB: new_top = ent[1] - ent[0];
      isa_pkg::STK_MUL: new_top = ent[1] * ent[0];
      default:          new_top = push_data;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift register of entries, entry 0 is the top
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // contents hold while the core sits in reset
  always_ff @(posedge clk) begin
    if (!rst) begin
      case (op)
        isa_pkg::STK_PUSH: begin
          ent[0] <= new_top;
          for (int i = 1; i < isa_pkg::STACK_DEPTH; i++) begin
            ent[i] <= ent[i-1];
          end
        end
        isa_pkg::STK_ADD,
        isa_pkg::STK_SUB,
        isa_pkg::STK_MUL: begin
          ent[0] <= new_top;
          for (int i = 1; i < isa_pkg::STACK_DEPTH - 1; i++) begin
            ent[i] <= ent[i+1];
          end
        end
        isa_pkg::STK_DROP2: begin
          // top stays, everything below it moves up one place
          for (int i = 1; i < isa_pkg::STACK_DEPTH - 1; i++) begin
            ent[i] <= ent[i+1];
          end
        end
        isa_pkg::STK_POP: begin
          for (int i = 0; i < isa_pkg::STACK_DEPTH - 1; i++) begin
            ent[i] <= ent[i+1];
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* rtl/stack_cpu.sv */
module stack_cpu (
  input  logic                     clk,
  input  logic                     rst,
  input  isa_pkg::insn_t           insn,
  output logic [mem_pkg::PC_W-1:0] pc,
  output mem_pkg::dmem_req_t       dmem,
  input  logic [7:0]               rd_data,
  output logic [7:0]               out_data,
  output logic                     out_valid
);

  isa_pkg::phase_t    phase;
  isa_pkg::stack_op_t stk_op;
  logic [7:0]         push_val;
  logic [7:0]         top;
  logic [7:0]         second;
  logic [7:0]         daddr;
  logic               dwe;
  logic [7:0]         dwdata;
  logic               is_halt;

  assign is_halt = (insn == isa_pkg::INSN_HALT);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // phase counter and program counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= isa_pkg::PH_EXEC;
    end else begin
      phase <= isa_pkg::phase_t'(phase + 2'd1);
    end
  end

  // the new pc is fetched during advance so the word is ready for exec
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (phase == isa_pkg::PH_ACCESS && !is_halt) begin
      pc <= pc + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    stk_op   = isa_pkg::STK_NONE;
    push_val = insn.operand;
    if (phase == isa_pkg::PH_ACCESS) begin
      case (insn.opcode)
        isa_pkg::OP_PUSH: stk_op = isa_pkg::STK_PUSH;
        isa_pkg::OP_ADD:  stk_op = isa_pkg::STK_ADD;
        isa_pkg::OP_SUB:  stk_op = isa_pkg::STK_SUB;
        isa_pkg::OP_MUL:  stk_op = isa_pkg::STK_MUL;
        isa_pkg::OP_STORE: begin
          // operand 0 took its address from the second entry, so drop that one
          stk_op = (insn.operand == 8'd0) ? isa_pkg::STK_DROP2 : isa_pkg::STK_POP;
        end
        isa_pkg::OP_LOAD: begin
          stk_op   = isa_pkg::STK_PUSH;
          push_val = rd_data;
        end
        default: stk_op = isa_pkg::STK_NONE;
      endcase
    end
  end

  // small operands select a stack entry as the address
  always_comb begin
    if (insn.operand[7:1] != 7'd0) begin
      daddr = insn.operand;
    end else if (insn.opcode == isa_pkg::OP_STORE) begin
      daddr = second;
    end else begin
      daddr = top;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data memory and output registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dwe <= 1'b0;
    end else begin
      dwe <= (phase == isa_pkg::PH_ADDR) && (insn.opcode == isa_pkg::OP_STORE);
    end
  end

  always_ff @(posedge clk) begin
    if (phase == isa_pkg::PH_ADDR) begin
      dwdata <= top;
    end
  end

  assign dmem = '{addr: daddr, we: dwe, wdata: dwdata};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_data  <= 8'd0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (phase == isa_pkg::PH_EXEC && insn.opcode == isa_pkg::OP_OUT) begin
        out_data  <= top;
        out_valid <= 1'b1;
      end
    end
  end

  operand_stack u_stack (
    .clk       (clk),
    .rst       (rst),
    .op        (stk_op),
    .push_data (push_val),
    .top       (top),
    .second    (second)
  );

endmodule

/* rtl/stack_cpu_top.sv */
module stack_cpu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prog_we,
  input  mem_pkg::prog_load_t      prog,
  output logic [mem_pkg::PC_W-1:0] pc,
  output logic [7:0]               out_data,
  output logic                     out_valid
);

  isa_pkg::insn_t                 insn;
  mem_pkg::dmem_req_t             dreq;
  logic [mem_pkg::DATA_W-1:0]     rd_data;
  logic                           imem_we;

  // the program port only writes while the core is held in reset
  assign imem_we = prog_we & rst;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  stack_cpu u_cpu (
    .clk       (clk),
    .rst       (rst),
    .insn      (insn),
    .pc        (pc),
    .dmem      (dreq),
    .rd_data   (rd_data),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memories
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  word_mem #(
    .word_t (isa_pkg::insn_t),
    .DEPTH  (mem_pkg::IMEM_DEPTH)
  ) u_imem (
    .clk   (clk),
    .we    (imem_we),
    .waddr (prog.addr),
    .wdata (prog.word),
    .raddr (pc),
    .rdata (insn)
  );

  // single address serves both the read and the write side
  word_mem #(
    .word_t (logic [mem_pkg::DATA_W-1:0]),
    .DEPTH  (mem_pkg::DMEM_DEPTH)
  ) u_dmem (
    .clk   (clk),
    .we    (dreq.we),
    .waddr (dreq.addr),
    .wdata (dreq.wdata),
    .raddr (dreq.addr),
    .rdata (rd_data)
  );

endmodule

/* bench/tb_tasks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program building and loading
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic logic [7:0] rand_byte();
  integer r;
  r = $random(seed);
  return r[7:0];
endfunction

task automatic clear_program();
  prog_len = 0;
endtask

task automatic add_insn(input logic [7:0] opcode, input logic [7:0] operand);
  prog_words[prog_len] = {opcode, operand};
  prog_len++;
endtask

task automatic add_halt();
  prog_words[prog_len] = 16'hffff;
  prog_len++;
endtask

// holds the core in reset for at least 4 cycles while the words go in
task automatic load_program();
  int i;
  int held;
  run_model();
  @(posedge clk);
  rst <= 1'b1;
  prog_we <= 1'b0;
  held = 1;
  for (i = 0; i < prog_len; i++) begin
    @(posedge clk);
    prog_we <= 1'b1;
    prog.addr <= i[mem_pkg::PC_W-1:0];
    prog.word <= prog_words[i];
    held++;
  end
  @(posedge clk);
  prog_we <= 1'b0;
  held++;
  while (held < 4) begin
    @(posedge clk);
    held++;
  end
  // word 0 is already readable when the core leaves reset
  @(posedge clk);
  rst <= 1'b0;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checks and waits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic compare_byte(input string what, input logic [7:0] got, input logic [7:0] want);
  assert (got === want) else begin
    $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, want);
    errors++;
  end
endtask

task automatic compare_pc(input string what, input logic [mem_pkg::PC_W-1:0] want);
  assert (pc === want) else begin
    $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, pc, want);
    errors++;
  end
endtask

task automatic wait_out_pulse(input int limit, output int waited, output logic seen);
  waited = 0;
  seen = 1'b0;
  while (!seen && waited < limit) begin
    @(posedge clk);
    waited++;
    seen = out_valid;
  end
  assert (seen) else begin
    $display("timeout: no out_valid pulse arrived within %0d cycles", limit);
    timeouts++;
  end
endtask

// checks every pulse against the model until pc has stopped moving
task automatic run_to_halt();
  int                       cyc;
  int                       still;
  int                       limit;
  logic [7:0]               want;
  logic [mem_pkg::PC_W-1:0] last_pc;
  cyc = 0;
  still = 0;
  limit = prog_len * 4 + 40;
  last_pc = pc;
  while (still < 12 && cyc < limit) begin
    @(posedge clk);
    cyc++;
    if (out_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("[ERROR] %0t: unexpected out_valid with data %0h", $time, out_data);
        errors++;
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        compare_byte("out_data", out_data, want);
      end
    end
    if (pc == last_pc) begin
      still++;
    end else begin
      still = 0;
    end
    last_pc = pc;
  end
  assert (still >= 12) else begin
    $display("timeout: pc was still moving after %0d cycles, no halt reached", limit);
    timeouts++;
  end
  assert (int'(pc) == halt_pc) else begin
    $display("[ERROR] %0t: pc stopped at %0d, halt is at %0d", $time, pc, halt_pc);
    errors++;
  end
  assert (exp_q.size() == 0) else begin
    $display("[ERROR] %0t: %0d expected outputs never appeared", $time, exp_q.size());
    errors++;
  end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_reset_push();
  logic [7:0] a;
  logic [7:0] b;
  int         waited;
  logic       seen;
  a = rand_byte();
  b = rand_byte();
  clear_program();
  add_insn(isa_pkg::OP_PUSH, a);
  add_insn(isa_pkg::OP_PUSH, b);
  add_insn(isa_pkg::OP_OUT, 8'd0);
  add_halt();
  load_program();
  compare_byte("out_valid after reset", {7'd0, out_valid}, 8'd0);
  compare_byte("out_data after reset", out_data, 8'd0);
  compare_pc("pc after reset", '0);
  wait_out_pulse(40, waited, seen);
  if (seen) begin
    compare_byte("first output", out_data, b);
    exp_q.delete();
  end
  run_to_halt();
endtask

task automatic arith_random_pairs();
  logic [7:0] arith_op [3];
  int         k;
  int         j;
  arith_op[0] = isa_pkg::OP_ADD;
  arith_op[1] = isa_pkg::OP_SUB;
  arith_op[2] = isa_pkg::OP_MUL;
  clear_program();
  for (k = 0; k < 3; k++) begin
    for (j = 0; j < 3; j++) begin
      add_insn(isa_pkg::OP_PUSH, rand_byte());
      add_insn(isa_pkg::OP_PUSH, rand_byte());
      add_insn(arith_op[j], 8'd0);
      add_insn(isa_pkg::OP_OUT, 8'd0);
      // a store to a scratch address just pops the result
      add_insn(isa_pkg::OP_STORE, 8'hff);
    end
  end
  add_halt();
  load_program();
  run_to_halt();
endtask

task automatic store_load_direct();
  logic [7:0] adr;
  int         k;
  clear_program();
  for (k = 0; k < 4; k++) begin
    adr = rand_byte();
    if (adr < 8'd2) adr = adr + 8'd2;
    add_insn(isa_pkg::OP_PUSH, rand_byte());
    add_insn(isa_pkg::OP_STORE, adr);
    add_insn(isa_pkg::OP_LOAD, adr);
    add_insn(isa_pkg::OP_OUT, 8'd0);
    add_insn(isa_pkg::OP_STORE, 8'hfe);
  end
  add_halt();
  load_program();
  run_to_halt();
endtask

task automatic store_load_via_stack();
  logic [7:0] adr;
  logic [7:0] v;
  adr = rand_byte();
  v = rand_byte();
  clear_program();
  add_insn(isa_pkg::OP_PUSH, adr);
  add_insn(isa_pkg::OP_PUSH, v);
  add_insn(isa_pkg::OP_STORE, 8'd0);
  add_insn(isa_pkg::OP_OUT, 8'd0);
  add_insn(isa_pkg::OP_PUSH, adr);
  add_insn(isa_pkg::OP_LOAD, 8'd0);
  add_insn(isa_pkg::OP_OUT, 8'd0);
  // two pops bring the kept top back up
  add_insn(isa_pkg::OP_STORE, 8'd1);
  add_insn(isa_pkg::OP_STORE, 8'd1);
  add_insn(isa_pkg::OP_OUT, 8'd0);
  add_halt();
  load_program();
  run_to_halt();
endtask

task automatic halt_freezes_pc();
  logic [7:0] v;
  int         k;
  v = rand_byte();
  clear_program();
  add_insn(isa_pkg::OP_PUSH, v);
  add_insn(isa_pkg::OP_OUT, 8'd0);
  add_halt();
  add_insn(isa_pkg::OP_PUSH, v + 8'd1);
  add_insn(isa_pkg::OP_OUT, 8'd0);
  load_program();
  run_to_halt();
  for (k = 0; k < 40; k++) begin
    @(posedge clk);
    compare_byte("out_valid after halt", {7'd0, out_valid}, 8'd0);
    compare_pc("pc after halt", halt_pc[mem_pkg::PC_W-1:0]);
  end
endtask

task automatic output_spacing();
  logic [7:0] want;
  int         waited;
  logic       seen;
  clear_program();
  add_insn(isa_pkg::OP_PUSH, rand_byte());
  add_insn(isa_pkg::OP_OUT, 8'd0);
  add_insn(isa_pkg::OP_OUT, 8'd0);
  add_halt();
  load_program();
  wait_out_pulse(40, waited, seen);
  if (seen && exp_q.size() > 0) begin
    want = exp_q.pop_front();
    compare_byte("first output", out_data, want);
    @(posedge clk);
    compare_byte("out_valid one cycle after the pulse", {7'd0, out_valid}, 8'd0);
    wait_out_pulse(10, waited, seen);
    if (seen && exp_q.size() > 0) begin
      want = exp_q.pop_front();
      compare_byte("second output", out_data, want);
      assert (waited + 1 == 4) else begin
        $display("[ERROR] %0t: pulses came %0d cycles apart, expected 4", $time, waited + 1);
        errors++;
      end
    end
  end
  run_to_halt();
endtask

/* bench/tb_stack_cpu.sv */
module tb_stack_cpu;

  logic                     clk;
  logic                     rst;
  logic                     prog_we;
  mem_pkg::prog_load_t      prog;
  logic [mem_pkg::PC_W-1:0] pc;
  logic [7:0]               out_data;
  logic                     out_valid;

  // program image, plus what the model expects the core to do with it
  logic [15:0] prog_words [128];
  int          prog_len;
  logic [7:0]  exp_q [$];
  int          halt_pc;
  logic [7:0]  dmem_model [256];

  int     errors;
  int     timeouts;
  integer seed;

  always #10 clk = ~clk;

  stack_cpu_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog      (prog),
    .pc        (pc),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // walks the program like an interpreter, st[sp-1] is the top of stack
  task automatic run_model();
    logic [7:0] st [64];
    int         sp;
    int         pc_m;
    logic [7:0] opc;
    logic [7:0] opd;
    int         a;
    int         b;
    logic [7:0] adr;
    logic       done;
    sp = 0;
    pc_m = 0;
    done = 1'b0;
    halt_pc = -1;
    exp_q.delete();
    while (!done && pc_m < prog_len) begin
      opc = prog_words[pc_m][15:8];
      opd = prog_words[pc_m][7:0];
      if (prog_words[pc_m] == 16'hffff) begin
        done = 1'b1;
        halt_pc = pc_m;
      end else begin
        case (opc)
          isa_pkg::OP_PUSH: begin
            st[sp] = opd;
            sp++;
          end
          isa_pkg::OP_OUT: exp_q.push_back(st[sp-1]);
          isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_MUL: begin
            a = st[sp-2];
            b = st[sp-1];
            sp--;
            if (opc == isa_pkg::OP_ADD) st[sp-1] = (a + b) % 256;
            else if (opc == isa_pkg::OP_SUB) st[sp-1] = (a - b + 256) % 256;
            else st[sp-1] = (a * b) % 256;
          end
          isa_pkg::OP_STORE: begin
            adr = (opd >= 2) ? opd : st[sp-2];
            dmem_model[adr] = st[sp-1];
            // operand 0 drops the address entry under the top
            if (opd == 8'd0) st[sp-2] = st[sp-1];
            sp--;
          end
          isa_pkg::OP_LOAD: begin
            adr = (opd >= 2) ? opd : st[sp-1];
            st[sp] = dmem_model[adr];
            sp++;
          end
          default: begin
          end
        endcase
        pc_m++;
      end
    end
  endtask

  `include "tb_tasks.svh"

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    prog_we = 1'b0;
    prog = '0;
    errors = 0;
    timeouts = 0;
    seed = 32'h7a2acf32;

    check_reset_push();
    arith_random_pairs();
    store_load_direct();
    store_load_via_stack();
    halt_freezes_pc();
    output_spacing();

    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* Bender.yml */
package:
  name: stack_cpu

sources:
  # packages first, the memory and core modules use their types
  - rtl/isa_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/word_mem.sv
  - rtl/operand_stack.sv
  - rtl/stack_cpu.sv
  - rtl/stack_cpu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_stack_cpu.sv

/* tb.f */
+incdir+bench
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/word_mem.sv
rtl/operand_stack.sv
rtl/stack_cpu.sv
rtl/stack_cpu_top.sv
bench/tb_stack_cpu.sv
